// ==== cluster_macros.svh ====
// Cluster width macros
// Compute unit count and field widths shared by the cluster RTL

`ifndef CLUSTER_MACROS_SVH
`define CLUSTER_MACROS_SVH

// Number of compute units in the cluster
`define CLUSTER_NUM_CU 4

// Program counter width
`define CLUSTER_PC_W 16

// Data / parameter address width
`define CLUSTER_ADDR_W 32

// Thread block index inside a thread group
`define CLUSTER_TBLOCK_IDX_W 8

// Thread group identifier
`define CLUSTER_TGROUP_ID_W 8

`endif

// ==== cluster_pkg.sv ====
// Cluster package
// Types for thread block dispatch and completion reporting

`include "cluster_macros.svh"

package cluster_pkg;

    // Index into the compute units, at least one bit wide
    localparam int unsigned cu_idx_w = (`CLUSTER_NUM_CU > 1) ? $clog2(`CLUSTER_NUM_CU) : 1;

    // One bit per compute unit
    typedef logic [`CLUSTER_NUM_CU-1:0] cu_mask_t;
    typedef logic [cu_idx_w-1:0]        cu_idx_t;

    // Descriptor fields
    typedef logic [`CLUSTER_PC_W-1:0]         pc_t;
    typedef logic [`CLUSTER_ADDR_W-1:0]       addr_t;
    typedef logic [`CLUSTER_TBLOCK_IDX_W-1:0] tblock_idx_t;
    typedef logic [`CLUSTER_TGROUP_ID_W-1:0]  tgroup_id_t;

    // Everything a compute unit needs to start a thread block
    typedef struct packed {
        pc_t         pc;
        addr_t       dp_addr;
        tblock_idx_t tblock_idx;
        tgroup_id_t  tgroup_id;
    } tblock_desc_t;

endpackage

// ==== compute_cluster.sv ====
// Compute cluster coordination layer
// Thread block dispatch to the compute units and completion report merging

`include "cluster_macros.svh"

module compute_cluster
    import cluster_pkg::*;
(
    input  logic                             clk_i,
    input  logic                             arst_n_i,

    // New thread block from the scheduler
    input  logic                             allocate_i,
    input  tblock_desc_t                     alloc_desc_i,
    output logic                             warp_free_o,

    // Dispatch to the compute units
    input  cu_mask_t                         cu_warp_free_i,
    output cu_mask_t                         cu_allocate_o,
    output tblock_desc_t                     cu_desc_o,

    // Completion reports from the compute units
    input  cu_mask_t                         cu_done_i,
    input  tgroup_id_t [`CLUSTER_NUM_CU-1:0] cu_done_id_i,
    output cu_mask_t                         cu_done_ready_o,

    // Merged completion stream
    output logic                             tblock_done_o,
    output tgroup_id_t                       tblock_done_id_o,
    input  logic                             tblock_done_ready_i
);

    // ############################
    // Thread block distribution
    // ############################

    tblock_dispatch u_tblock_dispatch (
        .clk_i          ( clk_i          ),
        .arst_n_i       ( arst_n_i       ),
        .allocate_i     ( allocate_i     ),
        .alloc_desc_i   ( alloc_desc_i   ),
        .cu_warp_free_i ( cu_warp_free_i ),
        .warp_free_o    ( warp_free_o    ),
        .cu_allocate_o  ( cu_allocate_o  ),
        .cu_desc_o      ( cu_desc_o      )
    );

    // ############################
    // Thread block completion
    // ############################

    done_arbiter u_done_arbiter (
        .clk_i               ( clk_i               ),
        .arst_n_i            ( arst_n_i            ),
        .cu_done_i           ( cu_done_i           ),
        .cu_done_id_i        ( cu_done_id_i        ),
        .cu_done_ready_o     ( cu_done_ready_o     ),
        .tblock_done_o       ( tblock_done_o       ),
        .tblock_done_id_o    ( tblock_done_id_o    ),
        .tblock_done_ready_i ( tblock_done_ready_i )
    );

endmodule

// ==== done_arbiter.sv ====
// Completion arbiter
// Merges the per-unit done reports round robin into one registered output slot

`include "cluster_macros.svh"

module done_arbiter
    import cluster_pkg::*;
(
    input  logic                               clk_i,
    input  logic                               arst_n_i,

    // Per-unit done streams
    input  cu_mask_t                           cu_done_i,
    input  tgroup_id_t [`CLUSTER_NUM_CU-1:0]   cu_done_id_i,
    output cu_mask_t                           cu_done_ready_o,

    // Merged done stream
    output logic                               tblock_done_o,
    output tgroup_id_t                         tblock_done_id_o,
    input  logic                               tblock_done_ready_i
);

    // Output slot state
    typedef enum logic {
        EMPTY,
        FULL
    } slot_state_e;

    slot_state_e state_q, state_d;
    cu_idx_t     ptr_q;
    tgroup_id_t  slot_id_q;

    logic        drain;
    logic        load_en;
    logic        grant_valid;
    cu_idx_t     grant_idx;
    logic        capture;

    // ############################
    // Slot control FSM
    // ############################

    // Slot empties when downstream takes it
    assign drain   = (state_q == FULL) && tblock_done_ready_i;
    // A new grant may load into an empty or draining slot
    assign load_en = (state_q == EMPTY) || drain;
    assign capture = load_en && grant_valid;

    always_comb begin
        state_d = state_q;
        case (state_q)
            EMPTY: begin
                if (capture) begin
                    state_d = FULL;
                end
            end
            FULL: begin
                // Back to back transfers keep the slot full
                if (drain && !capture) begin
                    state_d = EMPTY;
                end
            end
            default: state_d = EMPTY;
        endcase
    end

    // ############################
    // Round robin search
    // ############################

    // First valid unit at or after the pointer, wrapping around
    always_comb begin
        int unsigned cand;
        grant_valid = 1'b0;
        grant_idx   = '0;
        for (int unsigned off = 0; off < `CLUSTER_NUM_CU; off++) begin
            cand = int'(ptr_q) + off;
            if (cand >= `CLUSTER_NUM_CU) begin
                cand = cand - `CLUSTER_NUM_CU;
            end
            if (cu_done_i[cand] && !grant_valid) begin
                grant_valid = 1'b1;
                grant_idx   = cu_idx_t'(cand);
            end
        end
    end

    // Only the granted unit sees ready, and only when the slot takes it
    always_comb begin
        cu_done_ready_o = '0;
        if (capture) begin
            cu_done_ready_o[grant_idx] = 1'b1;
        end
    end

    // State and pointer
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= EMPTY;
            ptr_q   <= '0;
        end else begin
            state_q <= state_d;
            if (capture) begin
                // Next search starts one past the winner
                ptr_q <= (grant_idx == cu_idx_t'(`CLUSTER_NUM_CU - 1)) ? '0 : grant_idx + 1'b1;
            end
        end
    end

    // Slot payload, held while back-pressured
    always_ff @(posedge clk_i) begin
        if (capture) begin
            slot_id_q <= cu_done_id_i[grant_idx];
        end
    end

    assign tblock_done_o    = (state_q == FULL);
    assign tblock_done_id_o = slot_id_q;

endmodule

// ==== flist.f ====
+incdir+.
cluster_pkg.sv
tblock_dispatch.sv
done_arbiter.sv
compute_cluster.sv
tb_clock_gen.sv
tb_compute_cluster.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the compute cluster testbench with Verilator
# Pass or fail comes from the simulation log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary -f flist.f --top-module tb_compute_cluster \
    -Mdir "$BUILD_DIR" > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "Build failed with status $status, see $BUILD_LOG"
    exit 1
fi

"./$BUILD_DIR/Vtb_compute_cluster" > "$SIM_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status, see $SIM_LOG"
    exit 1
fi

grep -q "Finished with no errors" "$SIM_LOG"
status=$?
if [ $status -eq 0 ]; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see $SIM_LOG"
    exit 1
fi

// ==== tb_clock_gen.sv ====
// Testbench clock and reset source
// 100 ns clock, reset held low for the first 8 rising edges

module tb_clock_gen (
    output logic clk_o,
    output logic arst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int reset_cycles = 8;

    // Free running clock, 50 ns per half period
    initial begin
        clk_o = 1'b0;
        forever begin
            #50 clk_o = ~clk_o;
        end
    end

    // Release lines up with the stimulus offset after the last reset edge
    initial begin
        arst_n_o = 1'b0;
        repeat (reset_cycles) @(posedge clk_o);
        #5 arst_n_o = 1'b1;
    end

endmodule

// ==== tb_compute_cluster.sv ====
// Compute cluster testbench
// Random dispatch and completion traffic checked against a reference model

`include "cluster_macros.svh"

module tb_compute_cluster
    import cluster_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_cu      = `CLUSTER_NUM_CU;
    localparam int ids_per_cu  = 16;
    localparam int drain_limit = 2000;

    logic                             clk;
    logic                             arst_n;
    logic                             allocate;
    tblock_desc_t                     alloc_desc;
    logic                             warp_free;
    cu_mask_t                         cu_warp_free;
    cu_mask_t                         cu_allocate;
    tblock_desc_t                     cu_desc;
    cu_mask_t                         cu_done;
    tgroup_id_t [`CLUSTER_NUM_CU-1:0] cu_done_id;
    cu_mask_t                         cu_done_ready;
    logic                             tblock_done;
    tgroup_id_t                       tblock_done_id;
    logic                             tblock_done_ready;

    integer     seed = 32'hf9f8_f54f;
    string      test_name;
    logic       random_ready;
    // Dispatch model for the strobe expected after the next edge
    cu_mask_t     exp_alloc;
    tblock_desc_t exp_desc;
    // Compute unit models with one list of pending IDs per unit
    tgroup_id_t unit_ids [num_cu][ids_per_cu];
    int         unit_head [num_cu];
    int         unit_tail [num_cu];
    cu_mask_t   pop_mask;
    // Arbiter model
    logic       slot_full;
    int         rr_ptr;
    tgroup_id_t exp_out_q [$];
    logic       hold_pending;
    tgroup_id_t held_id;

    tb_clock_gen u_tb_clock_gen (
        .clk_o    ( clk    ),
        .arst_n_o ( arst_n )
    );

    compute_cluster u_compute_cluster (
        .clk_i               ( clk               ),
        .arst_n_i            ( arst_n            ),
        .allocate_i          ( allocate          ),
        .alloc_desc_i        ( alloc_desc        ),
        .warp_free_o         ( warp_free         ),
        .cu_warp_free_i      ( cu_warp_free      ),
        .cu_allocate_o       ( cu_allocate       ),
        .cu_desc_o           ( cu_desc           ),
        .cu_done_i           ( cu_done           ),
        .cu_done_id_i        ( cu_done_id        ),
        .cu_done_ready_o     ( cu_done_ready     ),
        .tblock_done_o       ( tblock_done       ),
        .tblock_done_id_o    ( tblock_done_id    ),
        .tblock_done_ready_i ( tblock_done_ready )
    );

    // ############################
    // Checking helpers
    // ############################

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("Error: %s %s expected %0h actual %0h",
                                        test_name, name, expected, actual));
        end
    endtask

    // Lowest numbered free unit as a one-hot mask
    function automatic cu_mask_t lowest_free_mask(input cu_mask_t free);
        cu_mask_t mask;
        mask = '0;
        for (int u = num_cu - 1; u >= 0; u--) begin
            if (free[u]) begin
                mask    = '0;
                mask[u] = 1'b1;
            end
        end
        return mask;
    endfunction

    function automatic logic all_drained();
        logic busy;
        busy = slot_full;
        for (int u = 0; u < num_cu; u++) begin
            if (unit_head[u] != unit_tail[u]) begin
                busy = 1'b1;
            end
        end
        return !busy;
    endfunction

    // ############################
    // Stimulus and unit models
    // ############################

    task automatic fill_unit_queues();
        logic [31:0] r;
        for (int u = 0; u < num_cu; u++) begin
            r            = $random(seed);
            unit_head[u] = 0;
            unit_tail[u] = 8 + int'(r[2:0]);
            for (int i = 0; i < unit_tail[u]; i++) begin
                r              = $random(seed);
                unit_ids[u][i] = tgroup_id_t'(r);
            end
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        logic [31:0] desc_hi;
        logic [31:0] desc_lo;
        r       = $random(seed);
        desc_hi = $random(seed);
        desc_lo = $random(seed);
        // Free pattern may be all zero, so some pulses must be ignored
        cu_warp_free      = cu_mask_t'(r);
        allocate          = (r[9:8] != 2'b00);
        alloc_desc        = tblock_desc_t'({desc_hi, desc_lo});
        tblock_done_ready = random_ready ? r[12] : 1'b1;
        for (int u = 0; u < num_cu; u++) begin
            // Valid drops only after a handshake
            if (pop_mask[u]) begin
                cu_done[u] = 1'b0;
            end
            if (!cu_done[u] && (unit_head[u] < unit_tail[u]) && r[16 + u]) begin
                cu_done[u]    = 1'b1;
                cu_done_id[u] = unit_ids[u][unit_head[u]];
            end
        end
    endtask

    // ############################
    // Reference model
    // ############################

    task automatic sample_and_model();
        cu_mask_t   exp_ready;
        tgroup_id_t exp_id;
        int         grant;
        int         cand;
        logic       load_en;
        // Registered dispatch outputs from the previous cycle
        check_value("cu_allocate_o", 64'(exp_alloc), 64'(cu_allocate));
        if (exp_alloc != '0) begin
            check_value("cu_desc_o", 64'(exp_desc), 64'(cu_desc));
        end
        check_value("warp_free_o", 64'(|cu_warp_free), 64'(warp_free));
        exp_alloc = '0;
        if (allocate && (cu_warp_free != '0)) begin
            exp_alloc = lowest_free_mask(cu_warp_free);
            exp_desc  = alloc_desc;
        end
        // Stalled slot keeps its ID
        if (hold_pending) begin
            check_value("tblock_done_id_o hold", 64'(held_id), 64'(tblock_done_id));
        end
        check_value("tblock_done_o", 64'(slot_full), 64'(tblock_done));
        // Search from one past the last grant when the slot can load
        load_en = !slot_full || tblock_done_ready;
        grant   = -1;
        if (load_en) begin
            for (int off = 0; off < num_cu; off++) begin
                cand = (rr_ptr + off) % num_cu;
                if (cu_done[cand] && (grant < 0)) begin
                    grant = cand;
                end
            end
        end
        exp_ready = '0;
        if (grant >= 0) begin
            exp_ready[grant] = 1'b1;
        end
        if (tblock_done && !tblock_done_ready) begin
            check_value("cu_done_ready_o stall", 64'(0), 64'(cu_done_ready));
        end
        check_value("cu_done_ready_o", 64'(exp_ready), 64'(cu_done_ready));
        // Output transfer at the coming edge
        if (slot_full && tblock_done_ready) begin
            if (exp_out_q.size() == 0) begin
                stop_with_failure("Output transfer seen with no completion in the model");
            end
            exp_id = exp_out_q.pop_front();
            check_value("tblock_done_id_o", 64'(exp_id), 64'(tblock_done_id));
            slot_full = 1'b0;
        end
        hold_pending = tblock_done && !tblock_done_ready;
        held_id      = tblock_done_id;
        pop_mask     = '0;
        if (grant >= 0) begin
            exp_out_q.push_back(unit_ids[grant][unit_head[grant]]);
            unit_head[grant]++;
            pop_mask[grant] = 1'b1;
            slot_full       = 1'b1;
            rr_ptr          = (grant + 1) % num_cu;
        end
    endtask

    // Drive just after the edge and sample once inputs have settled
    task automatic run_cycle();
        @(posedge clk);
        #5;
        drive_inputs();
        #1;
        sample_and_model();
    endtask

    task automatic drain_units(input string name, input logic with_backpressure);
        int cycles;
        test_name    = name;
        random_ready = with_backpressure;
        fill_unit_queues();
        cycles = 0;
        while (!all_drained()) begin
            run_cycle();
            cycles++;
            if (cycles > drain_limit) begin
                stop_with_failure($sformatf("Timeout in %s, completions still pending", name));
            end
        end
    endtask

    initial begin
        int cycles;
        allocate          = 1'b0;
        alloc_desc        = '0;
        cu_warp_free      = '0;
        cu_done           = '0;
        cu_done_id        = '0;
        tblock_done_ready = 1'b0;
        random_ready      = 1'b0;
        exp_alloc         = '0;
        exp_desc          = '0;
        pop_mask          = '0;
        slot_full         = 1'b0;
        rr_ptr            = 0;
        hold_pending      = 1'b0;
        held_id           = '0;
        test_name         = "reset";
        for (int u = 0; u < num_cu; u++) begin
            unit_head[u] = 0;
            unit_tail[u] = 0;
        end
        cycles = 0;
        while (arst_n !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > 20) begin
                stop_with_failure("Reset was never released");
            end
        end
        #1;
        check_value("cu_allocate_o", 64'(0), 64'(cu_allocate));
        check_value("cu_done_ready_o", 64'(0), 64'(cu_done_ready));
        check_value("tblock_done_o", 64'(0), 64'(tblock_done));
        // Dispatch only with no completion traffic yet
        test_name = "dispatch";
        repeat (300) run_cycle();
        drain_units("rr_ready_high", 1'b0);
        drain_units("rr_backpressure", 1'b1);
        // One more cycle shows the slot empty after the last transfer
        run_cycle();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== tblock_dispatch.sv ====
// Thread block dispatcher
// Sends a new block to the lowest numbered compute unit with a free warp

`include "cluster_macros.svh"

module tblock_dispatch
    import cluster_pkg::*;
(
    input  logic         clk_i,
    input  logic         arst_n_i,

    // Upstream allocation request
    input  logic         allocate_i,
    input  tblock_desc_t alloc_desc_i,
    output logic         warp_free_o,

    // Compute unit side
    input  cu_mask_t     cu_warp_free_i,
    output cu_mask_t     cu_allocate_o,
    output tblock_desc_t cu_desc_o
);

    // ############################
    // Free unit search
    // ############################

    cu_mask_t     first_free;
    cu_mask_t     allocate_q;
    tblock_desc_t desc_q;

    // Any unit with a free warp can take the block
    assign warp_free_o = |cu_warp_free_i;

    // Priority search, lowest index wins
    always_comb begin
        logic found;
        found      = 1'b0;
        first_free = '0;
        for (int unsigned cu = 0; cu < `CLUSTER_NUM_CU; cu++) begin
            if (cu_warp_free_i[cu] && !found) begin
                first_free[cu] = 1'b1;
                found          = 1'b1;
            end
        end
    end

    // ############################
    // Broadcast register stage
    // ############################

    // One cycle strobe, zero when nothing is free
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            allocate_q <= '0;
        end else begin
            allocate_q <= allocate_i ? first_free : '0;
        end
    end

    // Descriptor only follows an accepted allocation
    always_ff @(posedge clk_i) begin
        if (allocate_i && warp_free_o) begin
            desc_q <= alloc_desc_i;
        end
    end

    assign cu_allocate_o = allocate_q;
    assign cu_desc_o     = desc_q;

endmodule
